// ==== filelist.f ====
logic/xv_pkg.sv
logic/reg_interface.sv
logic/vram_arb.sv
logic/video_gen.sv
logic/xr_regs.sv
logic/video_main.sv
tb/video_checker.sv
tb/video_main_tb.sv

// ==== logic/reg_interface.sv ====
/*
 * cpu register interface
 * decodes the 8-bit bus into vram and xr word requests, keeps the
 * auto-increment addresses, read buffers and the interrupt mask
 */
`timescale 1ns/1ps
`default_nettype none

module reg_interface (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               bus_cs_n_i,     // one access per low cycle
    input  wire logic               bus_rd_nwr_i,
    input  wire logic [3:0]         bus_reg_num_i,
    input  wire logic               bus_bytesel_i,  // 0 even (high) byte, 1 odd byte
    input  wire logic [7:0]         bus_data_i,
    output logic      [7:0]         bus_data_o,
    output logic                    vram_sel_o,
    output xv_pkg::mem_req_t        vram_req_o,
    input  wire logic               vram_ack_i,
    input  wire xv_pkg::word_t      vram_data_i,
    output logic                    xr_sel_o,
    output xv_pkg::mem_req_t        xr_req_o,
    input  wire logic               xr_ack_i,
    input  wire xv_pkg::word_t      xr_data_i,
    input  wire xv_pkg::intr_t      intr_status_i,
    output xv_pkg::intr_t           intr_mask_o,
    output xv_pkg::intr_t           intr_clear_o
);

xv_pkg::reg_num_t   reg_num;
logic               bus_act;        // access taken this cycle
logic               word_wr;        // odd byte write completes word
logic               word_rd;        // odd byte read advances data ports
logic [7:0]         data_hi;        // latched even byte
xv_pkg::word_t      wr_word;
xv_pkg::word_t      rd_word;        // word for bus reads
xv_pkg::vram_addr_t wr_addr;
xv_pkg::vram_addr_t rd_addr;
xv_pkg::vram_addr_t rd_next;
xv_pkg::xr_addr_t   xr_addr;
xv_pkg::xr_addr_t   xr_next;
xv_pkg::word_t      rd_buf;         // vram prefetch
xv_pkg::word_t      xr_buf;         // xr prefetch

assign reg_num = xv_pkg::reg_num_t'(bus_reg_num_i);
assign bus_act = !bus_cs_n_i && !vram_sel_o && !xr_sel_o;   // dropped while busy
assign word_wr = bus_act && !bus_rd_nwr_i && bus_bytesel_i;
assign word_rd = bus_act && bus_rd_nwr_i && bus_bytesel_i;
assign wr_word = {data_hi, bus_data_i};
assign rd_next = rd_addr + 8'd1;
assign xr_next = xr_addr + 5'd1;

always_comb begin
    case (reg_num)
        xv_pkg::XM_WR_ADDR:  rd_word = {8'h00, wr_addr};
        xv_pkg::XM_RD_ADDR:  rd_word = {8'h00, rd_addr};
        xv_pkg::XM_DATA:     rd_word = rd_buf;
        xv_pkg::XM_XR_ADDR:  rd_word = {11'h000, xr_addr};
        xv_pkg::XM_XR_DATA:  rd_word = xr_buf;
        xv_pkg::XM_INT_CTRL: rd_word = {2{intr_mask_o, intr_status_i}};  // both bytes
        default:             rd_word = 16'h0000;
    endcase
end

// payload capture
always_ff @(posedge clk) begin
    if (bus_act && !bus_rd_nwr_i && !bus_bytesel_i) begin
        data_hi <= bus_data_i;
    end
    if (vram_ack_i && !vram_req_o.wr) begin
        rd_buf <= vram_data_i;                  // data valid with ack
    end
    if (xr_ack_i && !xr_req_o.wr) begin
        xr_buf <= xr_data_i;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_data_o   <= 8'h00;
        vram_sel_o   <= 1'b0;
        vram_req_o   <= '0;
        xr_sel_o     <= 1'b0;
        xr_req_o     <= '0;
        wr_addr      <= '0;
        rd_addr      <= '0;
        xr_addr      <= '0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
    end else begin
        intr_clear_o <= '0;                     // single cycle strobe
        if (vram_ack_i) vram_sel_o <= 1'b0;     // request held until ack
        if (xr_ack_i) xr_sel_o <= 1'b0;
        if (bus_act && bus_rd_nwr_i) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        end
        if (word_wr) begin
            case (reg_num)
                xv_pkg::XM_WR_ADDR: wr_addr <= wr_word[7:0];
                xv_pkg::XM_RD_ADDR: begin
                    rd_addr    <= wr_word[7:0];
                    vram_sel_o <= 1'b1;         // prefetch at new address
                    vram_req_o <= '{wr: 1'b0, addr: wr_word[7:0], data: 16'h0000};
                end
                xv_pkg::XM_DATA: begin
                    vram_sel_o <= 1'b1;
                    vram_req_o <= '{wr: 1'b1, addr: wr_addr, data: wr_word};
                    wr_addr    <= wr_addr + 8'd1;
                end
                xv_pkg::XM_XR_ADDR: begin
                    xr_addr  <= wr_word[4:0];
                    xr_sel_o <= 1'b1;
                    xr_req_o <= '{wr: 1'b0, addr: {3'b000, wr_word[4:0]}, data: 16'h0000};
                end
                xv_pkg::XM_XR_DATA: begin
                    xr_sel_o <= 1'b1;
                    xr_req_o <= '{wr: 1'b1, addr: {3'b000, xr_addr}, data: wr_word};
                    xr_addr  <= xr_next;
                end
                xv_pkg::XM_INT_CTRL: intr_mask_o <= wr_word[7:4];  // same spot as read
                xv_pkg::XM_INT_CLR:  intr_clear_o <= wr_word[3:0];
                default: ;
            endcase
        end
        if (word_rd) begin
            case (reg_num)
                xv_pkg::XM_DATA: begin
                    rd_addr    <= rd_next;      // advance and fetch next word
                    vram_sel_o <= 1'b1;
                    vram_req_o <= '{wr: 1'b0, addr: rd_next, data: 16'h0000};
                end
                xv_pkg::XM_XR_DATA: begin
                    xr_addr  <= xr_next;
                    xr_sel_o <= 1'b1;
                    xr_req_o <= '{wr: 1'b0, addr: {3'b000, xr_next}, data: 16'h0000};
                end
                default: ;
            endcase
        end
    end
end

// no back-pressure, cpu has to wait out a pending request
assert property (@(posedge clk) disable iff (reset_i)
    !bus_cs_n_i |-> !(vram_sel_o || xr_sel_o))
    else $error("bus access dropped while request pending");

endmodule

`default_nettype wire

// ==== logic/video_gen.sv ====
/*
 * video generator
 * raster counters and sync, vram word fetch per four pixels,
 * nibble shifter for colour indices and interrupt event pulses
 */
`timescale 1ns/1ps
`default_nettype none

module video_gen (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire xv_pkg::vram_addr_t vid_base_i,     // frame start word
    input  wire xv_pkg::word_t      vid_line_i,     // line compare
    output logic                    vram_sel_o,
    output xv_pkg::vram_addr_t      vram_addr_o,
    input  wire xv_pkg::word_t      vram_data_i,    // one cycle after fetch
    output xv_pkg::color_t          color_index_o,
    output xv_pkg::vid_sync_t       sync_o,
    output xv_pkg::intr_t           intr_signal_o
);

xv_pkg::hcount_t    h_count;
xv_pkg::vcount_t    v_count;
logic               h_last;
logic               v_last;
xv_pkg::vid_sync_t  raster_sync;    // sync at current count
xv_pkg::vid_sync_t  sync_p1;        // stage matching fetch data
logic               fetch_p1;       // vram data valid this cycle
xv_pkg::word_t      pix_shift;      // current pixel in top nibble
xv_pkg::vram_addr_t line_addr;

assign h_last = (h_count == xv_pkg::hcount_t'(xv_pkg::H_TOTAL - 1));
assign v_last = (v_count == xv_pkg::vcount_t'(xv_pkg::V_TOTAL - 1));

assign raster_sync.hsync = (h_count >= xv_pkg::H_SYNC_START) &&
                           (h_count < xv_pkg::H_SYNC_END);
assign raster_sync.vsync = (v_count == xv_pkg::V_SYNC_LINE);
assign raster_sync.de    = (h_count < xv_pkg::H_VISIBLE) && (v_count < xv_pkg::V_VISIBLE);

// base + line * words per line + group of four
assign line_addr   = vid_base_i + xv_pkg::vram_addr_t'(v_count * xv_pkg::WORDS_PER_LINE);
assign vram_sel_o  = raster_sync.de && (h_count[1:0] == 2'b00);
assign vram_addr_o = line_addr + xv_pkg::vram_addr_t'(h_count[4:2]);

assign color_index_o = pix_shift[15:12];    // high nibble first

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count <= '0;
        v_count <= '0;
    end else if (h_last) begin
        h_count <= '0;
        v_count <= v_last ? '0 : v_count + 4'd1;
    end else begin
        h_count <= h_count + 5'd1;
    end
end

// sync pipeline and event pulses
always_ff @(posedge clk) begin
    if (reset_i) begin
        sync_p1       <= '0;
        sync_o        <= '0;
        fetch_p1      <= 1'b0;
        intr_signal_o <= '0;
    end else begin
        sync_p1       <= raster_sync;
        sync_o        <= sync_p1;           // in step with color_index_o
        fetch_p1      <= vram_sel_o;
        intr_signal_o <= '0;
        if (h_count == '0) begin
            intr_signal_o[xv_pkg::INTR_VBLANK] <= (v_count == xv_pkg::V_VISIBLE);
            intr_signal_o[xv_pkg::INTR_LINE]   <= (vid_line_i == xv_pkg::word_t'(v_count));
        end
    end
end

always_ff @(posedge clk) begin
    if (fetch_p1) begin
        pix_shift <= vram_data_i;
    end else begin
        pix_shift <= {pix_shift[11:0], 4'h0};
    end
end

// fetched word reaches the colour stage inside the visible area
assert property (@(posedge clk) disable iff (reset_i)
    vram_sel_o |-> ##2 sync_o.de)
    else $error("vram fetch outside visible area");

endmodule

`default_nettype wire

// ==== logic/video_main.sv ====
/*
 * bitmap video controller top level
 * connects bus interface, vram, video generator and xr registers,
 * keeps interrupt status and drives the cpu interrupt
 */
`timescale 1ns/1ps
`default_nettype none

module video_main (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,
    input  wire logic           bus_rd_nwr_i,
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,     // registered read byte
    output logic                bus_intr_o,
    output xv_pkg::rgb_t        rgb_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

logic               vgen_vram_sel;
xv_pkg::vram_addr_t vgen_vram_addr;
xv_pkg::word_t      vram_data;          // shared vram read data
logic               regs_vram_sel;
xv_pkg::mem_req_t   regs_vram_req;
logic               regs_vram_ack;
logic               regs_xr_sel;
xv_pkg::mem_req_t   regs_xr_req;
logic               regs_xr_ack;
xv_pkg::word_t      xr_data;
xv_pkg::color_t     color_index;
xv_pkg::vid_sync_t  vgen_sync;
xv_pkg::vid_sync_t  out_sync;           // aligned with rgb_o
xv_pkg::word_t      vid_line;
xv_pkg::vram_addr_t vid_base;
xv_pkg::intr_t      intr_mask;          // enabled interrupts
xv_pkg::intr_t      intr_status;        // pending interrupts
xv_pkg::intr_t      intr_signal;        // video events
xv_pkg::intr_t      intr_clear;         // cpu clear strobe

reg_interface reg_interface (
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i), .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
    .vram_sel_o(regs_vram_sel), .vram_req_o(regs_vram_req),
    .vram_ack_i(regs_vram_ack), .vram_data_i(vram_data),
    .xr_sel_o(regs_xr_sel), .xr_req_o(regs_xr_req),
    .xr_ack_i(regs_xr_ack), .xr_data_i(xr_data),
    .intr_status_i(intr_status), .intr_mask_o(intr_mask), .intr_clear_o(intr_clear)
);

vram_arb vram_arb (
    .clk(clk),
    .vgen_sel_i(vgen_vram_sel), .vgen_addr_i(vgen_vram_addr),
    .regs_sel_i(regs_vram_sel), .regs_req_i(regs_vram_req), .regs_ack_o(regs_vram_ack),
    .vram_data_o(vram_data)
);

video_gen video_gen (
    .clk(clk), .reset_i(reset_i),
    .vid_base_i(vid_base), .vid_line_i(vid_line),
    .vram_sel_o(vgen_vram_sel), .vram_addr_o(vgen_vram_addr), .vram_data_i(vram_data),
    .color_index_o(color_index), .sync_o(vgen_sync), .intr_signal_o(intr_signal)
);

xr_regs xr_regs (
    .clk(clk), .reset_i(reset_i),
    .xr_sel_i(regs_xr_sel), .xr_req_i(regs_xr_req), .xr_ack_o(regs_xr_ack), .xr_data_o(xr_data),
    .color_index_i(color_index), .sync_i(vgen_sync), .rgb_o(rgb_o), .sync_o(out_sync),
    .vid_line_o(vid_line), .vid_base_o(vid_base)
);

assign hsync_o = out_sync.hsync;
assign vsync_o = out_sync.vsync;
assign dv_de_o = out_sync.de;

always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o  <= 1'b0;
        intr_status <= '0;
    end else begin
        bus_intr_o  <= |(intr_signal & intr_mask & ~intr_status);  // enabled and not pending
        intr_status <= (intr_status | intr_signal) & ~intr_clear;   // clear wins over event
    end
end

endmodule

`default_nettype wire

// ==== logic/vram_arb.sv ====
/*
 * vram array and arbiter
 * 256-word synchronous ram, video fetch has priority over register port
 */
`timescale 1ns/1ps
`default_nettype none

module vram_arb (
    input  wire logic               clk,
    input  wire logic               vgen_sel_i,     // video fetch
    input  wire xv_pkg::vram_addr_t vgen_addr_i,
    input  wire logic               regs_sel_i,
    input  wire xv_pkg::mem_req_t   regs_req_i,
    output logic                    regs_ack_o,     // one cycle after service
    output xv_pkg::word_t           vram_data_o     // shared read data
);

xv_pkg::word_t      vram [0:xv_pkg::VRAM_WORDS-1];
logic               regs_grant;     // register port served this cycle
xv_pkg::vram_addr_t mem_addr;

// first free cycle, not again while the ack is out
assign regs_grant = regs_sel_i && !vgen_sel_i && !regs_ack_o;
assign mem_addr   = vgen_sel_i ? vgen_addr_i : regs_req_i.addr;

always_ff @(posedge clk) begin
    if (regs_grant && regs_req_i.wr) begin
        vram[mem_addr] <= regs_req_i.data;
    end
    vram_data_o <= vram[mem_addr];      // read every cycle
    regs_ack_o  <= regs_grant;          // data lines up with ack
end

endmodule

`default_nettype wire

// ==== logic/xr_regs.sv ====
/*
 * xr register bus
 * colour lookup table, VID_LINE and VID_BASE, plus registered colour output
 */
`timescale 1ns/1ps
`default_nettype none

module xr_regs (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               xr_sel_i,
    input  wire xv_pkg::mem_req_t   xr_req_i,
    output logic                    xr_ack_o,       // always one cycle after select
    output xv_pkg::word_t           xr_data_o,
    input  wire xv_pkg::color_t     color_index_i,
    input  wire xv_pkg::vid_sync_t  sync_i,
    output xv_pkg::rgb_t            rgb_o,
    output xv_pkg::vid_sync_t       sync_o,
    output xv_pkg::word_t           vid_line_o,
    output xv_pkg::vram_addr_t      vid_base_o
);

xv_pkg::word_t  lut [0:xv_pkg::LUT_ENTRIES-1];  // rgb in low 12 bits
xv_pkg::word_t  vid_base;
xv_pkg::word_t  rd_word;
logic           xr_grant;
logic           lut_sel;

assign xr_grant   = xr_sel_i && !xr_ack_o;
assign lut_sel    = (xr_req_i.addr < xv_pkg::LUT_ENTRIES);
assign vid_base_o = vid_base[7:0];

always_comb begin
    if (lut_sel) rd_word = lut[xr_req_i.addr[3:0]];
    else if (xr_req_i.addr == 8'(xv_pkg::XR_VID_LINE)) rd_word = vid_line_o;
    else if (xr_req_i.addr == 8'(xv_pkg::XR_VID_BASE)) rd_word = vid_base;
    else rd_word = 16'h0000;    // unmapped
end

always_ff @(posedge clk) begin
    if (xr_grant && xr_req_i.wr && lut_sel) begin
        lut[xr_req_i.addr[3:0]] <= xr_req_i.data;
    end
    if (xr_grant) begin
        xr_data_o <= rd_word;   // valid with ack
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        xr_ack_o   <= 1'b0;
        vid_line_o <= '0;
        vid_base   <= '0;
    end else begin
        xr_ack_o <= xr_grant;
        if (xr_grant && xr_req_i.wr) begin
            if (xr_req_i.addr == 8'(xv_pkg::XR_VID_LINE)) vid_line_o <= xr_req_i.data;
            if (xr_req_i.addr == 8'(xv_pkg::XR_VID_BASE)) vid_base <= xr_req_i.data;
        end
    end
end

// colour stage, black in blanking
always_ff @(posedge clk) begin
    if (reset_i) begin
        rgb_o  <= '0;
        sync_o <= '0;
    end else begin
        rgb_o  <= sync_i.de ? xv_pkg::rgb_t'(lut[color_index_i][11:0]) : '0;
        sync_o <= sync_i;       // delayed with colour
    end
end

endmodule

`default_nettype wire

// ==== logic/xv_pkg.sv ====
/*
 * shared definitions for the bitmap video controller
 * word and address types, bus register numbers, raster and memory constants
 */
`default_nettype none

package xv_pkg;

typedef logic [15:0] word_t;        // vram or xr data word
typedef logic [7:0]  vram_addr_t;   // 256 vram words
typedef logic [4:0]  xr_addr_t;     // lut entries then video regs
typedef logic [3:0]  color_t;       // lut index
typedef logic [3:0]  intr_t;        // vblank at bit 0, line compare at bit 1
typedef logic [4:0]  hcount_t;      // holds 0 to H_TOTAL-1
typedef logic [3:0]  vcount_t;      // holds 0 to V_TOTAL-1

typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
} rgb_t;

typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;                       // display enable
} vid_sync_t;

typedef struct packed {
    logic       wr;                 // 1 write, 0 read
    vram_addr_t addr;               // xr requests use the low 5 bits
    word_t      data;
} mem_req_t;

// cpu bus register numbers
typedef enum logic [3:0] {
    XM_WR_ADDR  = 4'h0,
    XM_RD_ADDR  = 4'h1,
    XM_DATA     = 4'h2,
    XM_XR_ADDR  = 4'h3,
    XM_XR_DATA  = 4'h4,
    XM_INT_CTRL = 4'h5,             // mask write, {mask, status} read
    XM_INT_CLR  = 4'h6              // clear strobe
} reg_num_t;

localparam xr_addr_t XR_VID_LINE = 5'h10;   // line compare value
localparam xr_addr_t XR_VID_BASE = 5'h11;   // frame start word

localparam int VRAM_WORDS  = 256;
localparam int LUT_ENTRIES = 16;
localparam int INTR_VBLANK = 0;
localparam int INTR_LINE   = 1;

// tiny raster, one pixel per clock
localparam int H_VISIBLE      = 16;
localparam int H_TOTAL        = 24;
localparam int H_SYNC_START   = 18;
localparam int H_SYNC_END     = 21;
localparam int V_VISIBLE      = 8;
localparam int V_TOTAL        = 10;
localparam int V_SYNC_LINE    = 9;
localparam int WORDS_PER_LINE = H_VISIBLE / 4;  // four pixels per word

localparam int PIX_LATENCY = 3;     // raster count to rgb output

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the video controller testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module video_main_tb \
    -o sim_video_main \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/sim_video_main) \
    && echo "$sim_out" \
    && echo "$sim_out" | grep -qF '*** TEST PASSED ***' \
    && exit 0 \
    || { echo "$sim_out" | tail -n 1; exit 1; }

// ==== tb/video_checker.sv ====
/*
 * checker for the video controller
 * shadow model from observed bus writes, compares reads, pixels, sync and interrupt
 */
`timescale 1ns/1ps
`default_nettype none

module video_checker (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,
    input  wire logic           bus_rd_nwr_i,
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [7:0]     bus_data_i,
    input  wire logic [7:0]     rd_data_i,      // dut bus_data_o
    input  wire logic           intr_i,
    input  wire xv_pkg::rgb_t   rgb_i,
    input  wire logic           hsync_i,
    input  wire logic           vsync_i,
    input  wire logic           de_i,
    input  wire logic           check_pix_i,
    output int                  mismatch_count_o,
    output int                  pixel_count_o
);

xv_pkg::word_t      vram_m [0:xv_pkg::VRAM_WORDS-1];
xv_pkg::word_t      lut_m [0:xv_pkg::LUT_ENTRIES-1];
xv_pkg::word_t      line_m;
xv_pkg::word_t      base_m;
xv_pkg::vram_addr_t wr_addr_m;
xv_pkg::vram_addr_t rd_addr_m;
xv_pkg::xr_addr_t   xr_addr_m;
xv_pkg::intr_t      mask_m;
xv_pkg::intr_t      status_m;
xv_pkg::intr_t      clear_m;        // strobe seen by dut this cycle
logic [7:0]         hi_m;
logic               exp_intr;
logic               rd_pend;
logic [7:0]         rd_exp;
logic               armed;          // pixel compare for this frame
logic               rst_seen = 1'b0;
int                 oh;             // raster position shown at the outputs
int                 ov;
int                 settle;         // cycles since reset

initial begin
    mismatch_count_o = 0;
    pixel_count_o    = 0;
end

// lut entry of the nibble for (h, v), high nibble first
function automatic xv_pkg::rgb_t pixel_ref(input int h, input int v);
    xv_pkg::vram_addr_t a;
    xv_pkg::color_t     idx;
    a   = base_m[7:0] + xv_pkg::vram_addr_t'(v * xv_pkg::WORDS_PER_LINE + h / 4);
    idx = xv_pkg::color_t'(vram_m[a] >> (12 - 4 * (h % 4)));
    return xv_pkg::rgb_t'(lut_m[idx][11:0]);
endfunction

// event pulse as seen two cycles after raster h 0 of the line
function automatic xv_pkg::intr_t event_ref(input int h, input int v, input xv_pkg::word_t l);
    xv_pkg::intr_t e;
    e = '0;
    if (h == xv_pkg::H_TOTAL - 2) begin
        e[xv_pkg::INTR_VBLANK] = (v == xv_pkg::V_VISIBLE - 1);
        e[xv_pkg::INTR_LINE]   = (int'(l) < xv_pkg::V_TOTAL) &&
                                 (v == (int'(l) + xv_pkg::V_TOTAL - 1) % xv_pkg::V_TOTAL);
    end
    return e;
endfunction

function automatic xv_pkg::word_t xr_word(input xv_pkg::xr_addr_t a);
    if (a < 5'(xv_pkg::LUT_ENTRIES)) return lut_m[a[3:0]];
    if (a == xv_pkg::XR_VID_LINE) return line_m;
    if (a == xv_pkg::XR_VID_BASE) return base_m;
    return 16'h0000;
endfunction

function automatic xv_pkg::word_t reg_word(input logic [3:0] num);
    case (num)
        xv_pkg::XM_WR_ADDR:  return {8'h00, wr_addr_m};
        xv_pkg::XM_RD_ADDR:  return {8'h00, rd_addr_m};
        xv_pkg::XM_DATA:     return vram_m[rd_addr_m];
        xv_pkg::XM_XR_ADDR:  return {11'h000, xr_addr_m};
        xv_pkg::XM_XR_DATA:  return xr_word(xr_addr_m);
        xv_pkg::XM_INT_CTRL: return {mask_m, status_m, mask_m, status_m};
        default:             return 16'h0000;
    endcase
endfunction

always @(posedge clk) begin : watch
    xv_pkg::word_t  w;
    xv_pkg::intr_t  sig;
    xv_pkg::intr_t  mask_n;
    xv_pkg::intr_t  clear_n;
    logic           exp_hs;
    logic           exp_vs;
    logic           exp_de;
    if (reset_i) begin
        if (rst_seen && (intr_i || hsync_i || vsync_i || de_i || rgb_i != '0)) begin
            $display("mismatch at %0t: outputs not idle in reset", $time);
            mismatch_count_o++;
        end
        rst_seen  = 1'b1;
        oh        = xv_pkg::H_TOTAL - xv_pkg::PIX_LATENCY;  // raster (0,0) minus latency
        ov        = xv_pkg::V_TOTAL - 1;
        settle    = 0;
        armed     = 1'b0;
        rd_pend   = 1'b0;
        exp_intr  = 1'b0;
        wr_addr_m = '0;
        rd_addr_m = '0;
        xr_addr_m = '0;
        mask_m    = '0;
        status_m  = '0;
        clear_m   = '0;
        line_m    = '0;
        base_m    = '0;
    end else begin
        if (rd_pend && rd_data_i !== rd_exp) begin
            $display("mismatch at %0t: read byte %h, expected %h", $time, rd_data_i, rd_exp);
            mismatch_count_o++;
        end
        rd_pend = 1'b0;
        if (intr_i !== exp_intr) begin
            $display("mismatch at %0t: bus_intr_o %b, expected %b", $time, intr_i, exp_intr);
            mismatch_count_o++;
        end
        exp_hs = (oh >= xv_pkg::H_SYNC_START) && (oh < xv_pkg::H_SYNC_END);
        exp_vs = (ov == xv_pkg::V_SYNC_LINE);
        exp_de = (oh < xv_pkg::H_VISIBLE) && (ov < xv_pkg::V_VISIBLE);
        if (oh == 0 && ov == 0) armed = check_pix_i;
        if (!check_pix_i) armed = 1'b0;
        if (settle >= xv_pkg::PIX_LATENCY) begin
            if ({hsync_i, vsync_i, de_i} !== {exp_hs, exp_vs, exp_de}) begin
                $display("mismatch at %0t: sync %b%b%b at (%0d,%0d)", $time,
                         hsync_i, vsync_i, de_i, oh, ov);
                mismatch_count_o++;
            end
            if (!de_i && rgb_i !== '0) begin
                $display("mismatch at %0t: rgb %h in blanking", $time, rgb_i);
                mismatch_count_o++;
            end
        end
        if (armed && de_i) begin
            pixel_count_o++;
            if (rgb_i !== pixel_ref(oh, ov)) begin
                $display("mismatch at %0t: pixel (%0d,%0d) rgb %h, expected %h", $time,
                         oh, ov, rgb_i, pixel_ref(oh, ov));
                mismatch_count_o++;
            end
        end
        // bus decode, reads see this cycle's state
        mask_n  = mask_m;
        clear_n = '0;
        if (!bus_cs_n_i && bus_rd_nwr_i) begin
            w       = reg_word(bus_reg_num_i);
            rd_exp  = bus_bytesel_i ? w[7:0] : w[15:8];
            rd_pend = 1'b1;
            if (bus_bytesel_i && bus_reg_num_i == xv_pkg::XM_DATA) rd_addr_m++;
            if (bus_bytesel_i && bus_reg_num_i == xv_pkg::XM_XR_DATA) xr_addr_m++;
        end else if (!bus_cs_n_i && !bus_bytesel_i) begin
            hi_m = bus_data_i;
        end else if (!bus_cs_n_i) begin
            w = {hi_m, bus_data_i};
            case (bus_reg_num_i)
                xv_pkg::XM_WR_ADDR: wr_addr_m = w[7:0];
                xv_pkg::XM_RD_ADDR: rd_addr_m = w[7:0];
                xv_pkg::XM_DATA: begin
                    vram_m[wr_addr_m] = w;
                    wr_addr_m++;
                end
                xv_pkg::XM_XR_ADDR: xr_addr_m = w[4:0];
                xv_pkg::XM_XR_DATA: begin
                    if (xr_addr_m < 5'(xv_pkg::LUT_ENTRIES)) lut_m[xr_addr_m[3:0]] = w;
                    else if (xr_addr_m == xv_pkg::XR_VID_LINE) line_m = w;
                    else if (xr_addr_m == xv_pkg::XR_VID_BASE) base_m = w;
                    xr_addr_m++;
                end
                xv_pkg::XM_INT_CTRL: mask_n = w[7:4];
                xv_pkg::XM_INT_CLR:  clear_n = w[3:0];
                default: ;
            endcase
        end
        // interrupt model, clear beats a new event
        sig      = event_ref(oh, ov, line_m);
        exp_intr = |(sig & mask_m & ~status_m);
        status_m = (status_m | sig) & ~clear_m;
        clear_m  = clear_n;
        mask_m   = mask_n;
        oh++;
        if (oh == xv_pkg::H_TOTAL) begin
            oh = 0;
            ov = (ov + 1) % xv_pkg::V_TOTAL;
        end
        if (settle < xv_pkg::PIX_LATENCY) settle++;
    end
end

endmodule

`default_nettype wire

// ==== tb/video_main_tb.sv ====
/*
 * testbench for the bitmap video controller
 * drives the cpu bus with word tasks, fills vram and lut with xorshift data
 */
`timescale 1ns/1ps
`default_nettype none

module video_main_tb;

localparam int ACCESS_CYCLES = 5;       // access cycle plus four idle
localparam int ACCESSES      = 280;     // upper bound on the bus accesses below
localparam int FRAMES        = 12;
localparam int CYCLE_LIMIT   = ACCESSES * ACCESS_CYCLES +
                               FRAMES * xv_pkg::H_TOTAL * xv_pkg::V_TOTAL;
localparam int VRAM_FILL     = 48;      // covers base 0 and base 16 frames
localparam int MIN_PIXELS    = 3 * xv_pkg::H_VISIBLE * xv_pkg::V_VISIBLE;

logic           clk = 1'b0;
logic           reset_i;
logic           bus_cs_n_i;
logic           bus_rd_nwr_i;
logic [3:0]     bus_reg_num_i;
logic           bus_bytesel_i;
logic [7:0]     bus_data_i;
logic [7:0]     bus_data_o;
logic           bus_intr_o;
xv_pkg::rgb_t   rgb_o;
logic           hsync_o;
logic           vsync_o;
logic           dv_de_o;
logic           check_pix;              // pixel compare enable
logic [31:0]    rand_state;
int             cycle_count = 0;
int             other_errors = 0;
int             mismatch_count;
int             pixel_count;

always #20 clk = ~clk;                  // 40 ns period

video_main UUT (
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i), .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i), .bus_data_o(bus_data_o),
    .bus_intr_o(bus_intr_o), .rgb_o(rgb_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

video_checker vid_checker (
    .clk(clk), .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i), .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i),
    .rd_data_i(bus_data_o), .intr_i(bus_intr_o), .rgb_i(rgb_o),
    .hsync_i(hsync_o), .vsync_i(vsync_o), .de_i(dv_de_o), .check_pix_i(check_pix),
    .mismatch_count_o(mismatch_count), .pixel_count_o(pixel_count)
);

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
endfunction

// one bus cycle then idle while pending requests finish
task automatic bus_access(input logic rd, input xv_pkg::reg_num_t num,
                          input logic odd, input logic [7:0] data);
    @(posedge clk);
    #5;
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = rd;
    bus_reg_num_i = num;
    bus_bytesel_i = odd;
    bus_data_i    = data;
    @(posedge clk);
    #5;
    bus_cs_n_i = 1'b1;
    repeat (ACCESS_CYCLES - 2) @(posedge clk);
endtask

task automatic write_word(input xv_pkg::reg_num_t num, input xv_pkg::word_t w);
    bus_access(1'b0, num, 1'b0, w[15:8]);   // even byte is high
    bus_access(1'b0, num, 1'b1, w[7:0]);
endtask

task automatic read_word(input xv_pkg::reg_num_t num);
    bus_access(1'b1, num, 1'b0, 8'h00);     // checker compares bytes
    bus_access(1'b1, num, 1'b1, 8'h00);
endtask

task automatic wait_frames(input int n);
    repeat (n) @(posedge vsync_o);
endtask

task automatic random_words(input xv_pkg::reg_num_t num, input int n);
    for (int i = 0; i < n; i++) begin
        rand_state = xorshift(rand_state);
        write_word(num, rand_state[15:0]);
    end
endtask

// run limit
always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT) begin
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** TEST FAILED ***");
        $finish;
    end
end

initial begin
    reset_i       = 1'b1;
    bus_cs_n_i    = 1'b1;
    bus_rd_nwr_i  = 1'b0;
    bus_reg_num_i = 4'h0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = 8'h00;
    check_pix     = 1'b0;
    rand_state    = 32'd73011;
    repeat (2) @(posedge clk);
    #5 reset_i = 1'b0;
    read_word(xv_pkg::XM_INT_CTRL);         // mask and status after reset
    // vram fill with auto-increment spanning display and blanking
    write_word(xv_pkg::XM_WR_ADDR, 16'h0000);
    random_words(xv_pkg::XM_DATA, VRAM_FILL);
    write_word(xv_pkg::XM_RD_ADDR, 16'h0000);
    for (int i = 0; i < 32; i++) read_word(xv_pkg::XM_DATA);
    // lut then video regs
    write_word(xv_pkg::XM_XR_ADDR, 16'h0000);
    random_words(xv_pkg::XM_XR_DATA, xv_pkg::LUT_ENTRIES);
    write_word(xv_pkg::XM_XR_ADDR, 16'h0000);
    for (int i = 0; i < xv_pkg::LUT_ENTRIES; i++) read_word(xv_pkg::XM_XR_DATA);
    write_word(xv_pkg::XM_XR_ADDR, 16'(xv_pkg::XR_VID_LINE));
    write_word(xv_pkg::XM_XR_DATA, 16'h0005);   // line then base at the next address
    write_word(xv_pkg::XM_XR_DATA, 16'h0000);
    write_word(xv_pkg::XM_XR_ADDR, 16'(xv_pkg::XR_VID_LINE));
    read_word(xv_pkg::XM_XR_DATA);
    read_word(xv_pkg::XM_XR_DATA);
    // pixels at base 0
    #5 check_pix = 1'b1;
    wait_frames(3);
    check_pix = 1'b0;
    write_word(xv_pkg::XM_XR_ADDR, 16'(xv_pkg::XR_VID_BASE));
    write_word(xv_pkg::XM_XR_DATA, 16'h0010);
    #5 check_pix = 1'b1;
    wait_frames(2);
    check_pix = 1'b0;
    // interrupts with the mask still zero
    read_word(xv_pkg::XM_INT_CTRL);
    write_word(xv_pkg::XM_INT_CLR, 16'h000f);
    read_word(xv_pkg::XM_INT_CTRL);
    write_word(xv_pkg::XM_INT_CTRL, 16'h0010);  // vblank enabled
    wait_frames(2);
    read_word(xv_pkg::XM_INT_CTRL);
    write_word(xv_pkg::XM_INT_CLR, 16'h0001);
    read_word(xv_pkg::XM_INT_CTRL);
    wait_frames(1);
    write_word(xv_pkg::XM_INT_CTRL, 16'h0020);  // line compare only
    write_word(xv_pkg::XM_XR_ADDR, 16'(xv_pkg::XR_VID_LINE));
    @(posedge dv_de_o);                         // keep the update away from line start
    write_word(xv_pkg::XM_XR_DATA, 16'h0003);
    write_word(xv_pkg::XM_INT_CLR, 16'h0003);
    wait_frames(2);
    read_word(xv_pkg::XM_INT_CTRL);
    repeat (4) @(posedge clk);
    #5;
    if (pixel_count < MIN_PIXELS) begin
        $display("only %0d pixels were compared, expected at least %0d",
                 pixel_count, MIN_PIXELS);
        other_errors++;
    end
    $display("errors: %0d mismatches, %0d other", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule

`default_nettype wire
